/* Makefile */
# Verilator flow for the four-slot decode stage

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= decode_tb
FILELIST  ?= src.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* hw/decode_pipe_pkg.sv */
// decode pipe package: lane count, data width and the records passed between stages
package decode_pipe_pkg;

  localparam int LANES = 4;
  localparam int XLEN  = 64;

  // one fetch slot, slicer to lane
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     inst;
  } slot_t;

  // decoded operation, lane to grouper
  typedef struct packed {
    logic                                valid;
    logic [XLEN-1:0]                     pc;
    rv_isa_pkg::op_e                     op;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rd;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs1;
    logic [rv_isa_pkg::REG_ADDR_W-1:0]   rs2;
    logic [XLEN-1:0]                     imm;   // sign extended, zero for R and illegal
    logic                                uses_rs1;
    logic                                uses_rs2;
    logic                                writes_rd;
    logic                                illegal;
    logic                                is_ebreak;
  } dec_op_t;

  // incoming fetch packet
  typedef struct packed {
    logic [LANES-1:0]       mask;
    logic [XLEN-1:0]        pc;    // pc of slot 0
    logic [LANES-1:0][31:0] insts;
  } fetch_pkt_t;

  // outgoing decoded packet
  typedef struct packed {
    logic                   valid;
    dec_op_t [LANES-1:0]    ops;
    logic [LANES-1:0]       group_end;
  } dec_pkt_t;

endpackage

/* hw/decode_top.sv */
// decode top: four-slot RV64 decode stage, slicer then decoder lanes then issue grouper
`timescale 1ns/10ps

module decode_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        fetch_valid,
  input  decode_pipe_pkg::fetch_pkt_t fetch,
  output logic                        dec_valid,
  output decode_pipe_pkg::dec_pkt_t   dec
);

  decode_pipe_pkg::slot_t   [decode_pipe_pkg::LANES-1:0] slots;
  decode_pipe_pkg::dec_op_t [decode_pipe_pkg::LANES-1:0] lane_ops;

  fetch_slicer u_slicer (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .slots       (slots)
  );

  for (genvar i = 0; i < decode_pipe_pkg::LANES; i++) begin : g_lane
    inst_decoder u_lane (
      .clk  (clk),
      .rst  (rst),
      .slot (slots[i]),
      .op   (lane_ops[i])
    );
  end

  issue_grouper u_grouper (
    .clk       (clk),
    .rst       (rst),
    .lane_ops  (lane_ops),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  // three stages end to end, no stall
  a_latency: assert property (
    @(posedge clk) disable iff (rst) fetch_valid && (|fetch.mask) |-> ##3 dec_valid
  );

endmodule

/* hw/fetch_slicer.sv */
// fetch slicer: registers a fetch packet and splits it into per-slot records with pcs
`timescale 1ns/10ps

module fetch_slicer (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic                                             fetch_valid,
  input  decode_pipe_pkg::fetch_pkt_t                      fetch,
  output decode_pipe_pkg::slot_t [decode_pipe_pkg::LANES-1:0] slots
);

  logic [decode_pipe_pkg::LANES-1:0]       valid_q;
  logic [decode_pipe_pkg::XLEN-1:0]        base_pc_q;
  logic [decode_pipe_pkg::LANES-1:0][31:0] insts_q;

  // slot valid bits are strobes, one cycle per packet
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (fetch_valid) begin
      valid_q <= fetch.mask;
    end else begin
      valid_q <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      base_pc_q <= fetch.pc;
      insts_q   <= fetch.insts;
    end
  end

  always_comb begin
    for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
      slots[i].valid = valid_q[i];
      slots[i].pc    = base_pc_q + {{(decode_pipe_pkg::XLEN - 4){1'b0}}, 4'(i * 4)}; // base + 4i
      slots[i].inst  = insts_q[i];
    end
  end

  // an empty packet would give a strobe with no slot behind it
  a_mask_nonzero: assert property (
    @(posedge clk) disable iff (rst) fetch_valid |-> (|fetch.mask)
  );

endmodule

/* hw/inst_decoder.sv */
// inst decoder: one decode lane turning a fetch slot into a registered decoded operation
`timescale 1ns/10ps

module inst_decoder (
  input  logic                     clk,
  input  logic                     rst,
  input  decode_pipe_pkg::slot_t   slot,
  output decode_pipe_pkg::dec_op_t op
);

  logic [31:0] inst;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        is_ebreak;

  logic [decode_pipe_pkg::XLEN-1:0] imm_i;
  logic [decode_pipe_pkg::XLEN-1:0] imm_s;
  logic [decode_pipe_pkg::XLEN-1:0] imm_b;
  logic [decode_pipe_pkg::XLEN-1:0] imm_u;
  logic [decode_pipe_pkg::XLEN-1:0] imm_j;
  logic [decode_pipe_pkg::XLEN-1:0] shamt;

  rv_isa_pkg::op_e  op_key3;   // keyed on funct3 + opcode
  rv_isa_pkg::op_e  op_opc;    // keyed on opcode alone
  rv_isa_pkg::op_e  op_key7;   // keyed on funct7 + funct3 + opcode
  rv_isa_pkg::op_e  op_key6;   // keyed on funct6 + funct3 + opcode
  rv_isa_pkg::op_e  op_id;
  rv_isa_pkg::fmt_e fmt;

  decode_pipe_pkg::dec_op_t op_d;
  decode_pipe_pkg::dec_op_t op_q;
  logic                     valid_q;

  assign inst      = slot.inst;
  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7    = inst[31:25];
  assign is_ebreak = (inst == rv_isa_pkg::INST_EBREAK);

  assign imm_i = {{(decode_pipe_pkg::XLEN - 12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(decode_pipe_pkg::XLEN - 12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(decode_pipe_pkg::XLEN - 13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_u = {{(decode_pipe_pkg::XLEN - 32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(decode_pipe_pkg::XLEN - 21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};
  assign shamt = {{(decode_pipe_pkg::XLEN - 6){1'b0}}, inst[25:20]}; // srai only

  always_comb begin
    case ({funct3, opcode})
      {3'b000, rv_isa_pkg::OPC_JALR}:      op_key3 = rv_isa_pkg::OP_JALR;
      {3'b001, rv_isa_pkg::OPC_BRANCH}:    op_key3 = rv_isa_pkg::OP_BNE;
      {3'b010, rv_isa_pkg::OPC_LOAD}:      op_key3 = rv_isa_pkg::OP_LW;
      {3'b100, rv_isa_pkg::OPC_LOAD}:      op_key3 = rv_isa_pkg::OP_LBU;
      {3'b001, rv_isa_pkg::OPC_STORE}:     op_key3 = rv_isa_pkg::OP_SH;
      {3'b000, rv_isa_pkg::OPC_OP_IMM}:    op_key3 = rv_isa_pkg::OP_ADDI;
      {3'b011, rv_isa_pkg::OPC_OP_IMM}:    op_key3 = rv_isa_pkg::OP_SLTIU;
      {3'b100, rv_isa_pkg::OPC_OP_IMM}:    op_key3 = rv_isa_pkg::OP_XORI;
      {3'b111, rv_isa_pkg::OPC_OP_IMM}:    op_key3 = rv_isa_pkg::OP_ANDI;
      {3'b011, rv_isa_pkg::OPC_LOAD}:      op_key3 = rv_isa_pkg::OP_LD;
      {3'b011, rv_isa_pkg::OPC_STORE}:     op_key3 = rv_isa_pkg::OP_SD;
      {3'b000, rv_isa_pkg::OPC_OP_IMM_32}: op_key3 = rv_isa_pkg::OP_ADDIW;
      default:                             op_key3 = rv_isa_pkg::OP_ILLEGAL;
    endcase
  end

  always_comb begin
    case (opcode)
      rv_isa_pkg::OPC_LUI:   op_opc = rv_isa_pkg::OP_LUI;
      rv_isa_pkg::OPC_AUIPC: op_opc = rv_isa_pkg::OP_AUIPC;
      rv_isa_pkg::OPC_JAL:   op_opc = rv_isa_pkg::OP_JAL;
      default:               op_opc = rv_isa_pkg::OP_ILLEGAL;
    endcase
  end

  always_comb begin
    case ({funct7, funct3, opcode})
      {rv_isa_pkg::F7_BASE, 3'b000, rv_isa_pkg::OPC_OP}:   op_key7 = rv_isa_pkg::OP_ADD;
      {rv_isa_pkg::F7_ALT,  3'b000, rv_isa_pkg::OPC_OP}:   op_key7 = rv_isa_pkg::OP_SUB;
      {rv_isa_pkg::F7_BASE, 3'b011, rv_isa_pkg::OPC_OP}:   op_key7 = rv_isa_pkg::OP_SLTU;
      {rv_isa_pkg::F7_BASE, 3'b110, rv_isa_pkg::OPC_OP}:   op_key7 = rv_isa_pkg::OP_OR;
      {rv_isa_pkg::F7_BASE, 3'b111, rv_isa_pkg::OPC_OP}:   op_key7 = rv_isa_pkg::OP_AND;
      {rv_isa_pkg::F7_BASE, 3'b000, rv_isa_pkg::OPC_OP_32}: op_key7 = rv_isa_pkg::OP_ADDW;
      {rv_isa_pkg::F7_BASE, 3'b001, rv_isa_pkg::OPC_OP_32}: op_key7 = rv_isa_pkg::OP_SLLW;
      default:                                              op_key7 = rv_isa_pkg::OP_ILLEGAL;
    endcase
  end

  // RV64 shifts keep bit 25 for shamt[5]
  assign op_key6 = ({inst[31:26], funct3, opcode} == {rv_isa_pkg::F6_SRA, 3'b101,
                    rv_isa_pkg::OPC_OP_IMM}) ? rv_isa_pkg::OP_SRAI : rv_isa_pkg::OP_ILLEGAL;

  // key spaces are disjoint, order only picks the hit
  always_comb begin
    if (is_ebreak) begin
      op_id = rv_isa_pkg::OP_EBREAK;
    end else if (op_key3 != rv_isa_pkg::OP_ILLEGAL) begin
      op_id = op_key3;
    end else if (op_opc != rv_isa_pkg::OP_ILLEGAL) begin
      op_id = op_opc;
    end else if (op_key7 != rv_isa_pkg::OP_ILLEGAL) begin
      op_id = op_key7;
    end else begin
      op_id = op_key6;
    end
  end

  always_comb begin
    case (op_id)
      rv_isa_pkg::OP_BNE:   fmt = rv_isa_pkg::FMT_B;
      rv_isa_pkg::OP_SH,
      rv_isa_pkg::OP_SD:    fmt = rv_isa_pkg::FMT_S;
      rv_isa_pkg::OP_LUI,
      rv_isa_pkg::OP_AUIPC: fmt = rv_isa_pkg::FMT_U;
      rv_isa_pkg::OP_JAL:   fmt = rv_isa_pkg::FMT_J;
      rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LW, rv_isa_pkg::OP_LBU, rv_isa_pkg::OP_ADDI,
      rv_isa_pkg::OP_SLTIU, rv_isa_pkg::OP_XORI, rv_isa_pkg::OP_ANDI, rv_isa_pkg::OP_LD,
      rv_isa_pkg::OP_ADDIW, rv_isa_pkg::OP_SRAI,
      rv_isa_pkg::OP_EBREAK: fmt = rv_isa_pkg::FMT_I;
      default:              fmt = rv_isa_pkg::FMT_R; // R ops and illegal
    endcase
  end

  always_comb begin
    op_d           = '0;
    op_d.valid     = slot.valid;
    op_d.pc        = slot.pc;
    op_d.op        = op_id;
    op_d.rd        = inst[11:7];
    op_d.rs1       = inst[19:15];
    op_d.rs2       = inst[24:20];
    op_d.illegal   = (op_id == rv_isa_pkg::OP_ILLEGAL);
    op_d.is_ebreak = is_ebreak;
    if (!op_d.illegal) begin
      case (fmt)
        rv_isa_pkg::FMT_I: begin
          op_d.uses_rs1  = 1'b1;
          op_d.writes_rd = 1'b1;
          op_d.imm       = (op_id == rv_isa_pkg::OP_SRAI) ? shamt : imm_i;
        end
        rv_isa_pkg::FMT_S: begin
          op_d.uses_rs1 = 1'b1;
          op_d.uses_rs2 = 1'b1;
          op_d.imm      = imm_s;
        end
        rv_isa_pkg::FMT_B: begin
          op_d.uses_rs1 = 1'b1;
          op_d.uses_rs2 = 1'b1;
          op_d.imm      = imm_b;
        end
        rv_isa_pkg::FMT_U: begin
          op_d.writes_rd = 1'b1;
          op_d.imm       = imm_u;
        end
        rv_isa_pkg::FMT_J: begin
          op_d.writes_rd = 1'b1;
          op_d.imm       = imm_j;
        end
        default: begin // R keeps imm at zero
          op_d.uses_rs1  = 1'b1;
          op_d.uses_rs2  = 1'b1;
          op_d.writes_rd = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= op_d.valid;
    end
  end

  always_ff @(posedge clk) begin
    op_q <= op_d;
  end

  always_comb begin
    op       = op_q;
    op.valid = valid_q;
  end

  a_ebreak_legal: assert property (
    @(posedge clk) disable iff (rst) slot.valid |=> !(op.illegal && op.is_ebreak)
  );

endmodule

/* hw/issue_grouper.sv */
// issue grouper: squashes slots after ebreak, marks issue group ends, registers the packet
`timescale 1ns/10ps

module issue_grouper (
  input  logic                                                clk,
  input  logic                                                rst,
  input  decode_pipe_pkg::dec_op_t [decode_pipe_pkg::LANES-1:0] lane_ops,
  output logic                                                dec_valid,
  output decode_pipe_pkg::dec_pkt_t                           dec
);

  decode_pipe_pkg::dec_op_t [decode_pipe_pkg::LANES-1:0] ops_k;  // after squash
  decode_pipe_pkg::dec_op_t [decode_pipe_pkg::LANES-1:0] ops_q;
  logic [decode_pipe_pkg::LANES-1:0]                     group_end_d;
  logic [decode_pipe_pkg::LANES-1:0]                     group_end_q;
  logic [decode_pipe_pkg::LANES-1:0]                     valid_q;
  logic                                                  any_valid;

  // true when rd of the writer feeds a used source of the reader
  function automatic logic raw_hit(decode_pipe_pkg::dec_op_t wr, decode_pipe_pkg::dec_op_t rd);
    logic hit;
    hit = 1'b0;
    if (wr.writes_rd && wr.rd != '0) begin
      hit = (rd.uses_rs1 && rd.rs1 == wr.rd) || (rd.uses_rs2 && rd.rs2 == wr.rd);
    end
    return hit;
  endfunction

  always_comb begin : squash
    logic seen_ebreak;
    seen_ebreak = 1'b0;
    any_valid   = 1'b0;
    for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
      ops_k[i] = lane_ops[i];
      any_valid = any_valid | lane_ops[i].valid;
      if (seen_ebreak) begin
        ops_k[i].valid = 1'b0;
      end
      if (lane_ops[i].valid && lane_ops[i].is_ebreak) begin
        seen_ebreak = 1'b1;
      end
    end
  end

  always_comb begin : grouping
    logic later_valid;
    for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
      group_end_d[i] = 1'b0;
      later_valid    = 1'b0;
      for (int j = i + 1; j < decode_pipe_pkg::LANES; j++) begin
        if (ops_k[j].valid) begin
          later_valid = 1'b1;
          if (raw_hit(ops_k[i], ops_k[j])) begin
            group_end_d[i] = 1'b1;
          end
        end
      end
      if (!later_valid) begin
        group_end_d[i] = 1'b1; // last valid slot closes the group
      end
      if (!ops_k[i].valid) begin
        group_end_d[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
      valid_q   <= '0;
    end else begin
      dec_valid <= any_valid;
      for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
        valid_q[i] <= ops_k[i].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    ops_q       <= ops_k;
    group_end_q <= group_end_d;
  end

  always_comb begin
    dec           = '0;
    dec.valid     = dec_valid;
    dec.group_end = group_end_q;
    for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
      dec.ops[i]       = ops_q[i];
      dec.ops[i].valid = valid_q[i];
    end
  end

  for (genvar g = 0; g < decode_pipe_pkg::LANES; g++) begin : g_chk
    a_last_ends: assert property (
      @(posedge clk) disable iff (rst)
      dec_valid && valid_q[g] && ((valid_q >> (g + 1)) == '0) |-> group_end_q[g]
    );
  end

endmodule

/* hw/rv_isa_pkg.sv */
// rv isa package: RV64 opcodes, formats and operation ids seen by the decode stage
package rv_isa_pkg;

  localparam int REG_ADDR_W = 5;

  // operation ids, one per supported instruction
  typedef enum logic [4:0] {
    OP_ILLEGAL = 5'd0,
    OP_JALR    = 5'd1,
    OP_BNE     = 5'd2,
    OP_LW      = 5'd3,
    OP_LBU     = 5'd4,
    OP_SH      = 5'd5,
    OP_ADDI    = 5'd6,
    OP_SLTIU   = 5'd7,
    OP_XORI    = 5'd8,
    OP_ANDI    = 5'd9,
    OP_LD      = 5'd10,
    OP_SD      = 5'd11,
    OP_ADDIW   = 5'd12,
    OP_LUI     = 5'd13,
    OP_AUIPC   = 5'd14,
    OP_JAL     = 5'd15,
    OP_ADD     = 5'd16,
    OP_SUB     = 5'd17,
    OP_SLTU    = 5'd18,
    OP_OR      = 5'd19,
    OP_AND     = 5'd20,
    OP_ADDW    = 5'd21,
    OP_SLLW    = 5'd22,
    OP_SRAI    = 5'd23,
    OP_EBREAK  = 5'd24
  } op_e;

  // immediate formats
  typedef enum logic [2:0] {
    FMT_R = 3'd0,
    FMT_I = 3'd1,
    FMT_S = 3'd2,
    FMT_B = 3'd3,
    FMT_U = 3'd4,
    FMT_J = 3'd5
  } fmt_e;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LOAD      = 7'b0000011;
  localparam logic [6:0] OPC_STORE     = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  // funct7 / funct6 keys
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam logic [5:0] F6_SRA  = 6'b010000;

  // ebreak is matched on the whole word
  localparam logic [31:0] INST_EBREAK = {12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM};

endpackage

/* src.f */
hw/rv_isa_pkg.sv
hw/decode_pipe_pkg.sv
hw/fetch_slicer.sv
hw/inst_decoder.sv
hw/issue_grouper.sv
hw/decode_top.sv
verif/decode_tb.sv

/* verif/decode_tb.sv */
// decode testbench: replays file vectors through the four-slot decode stage and checks results
`timescale 1ns/10ps

module decode_tb;

  localparam int NREC  = 14;             // records in the data file
  localparam int WPR   = 16;             // 64-bit words per record
  localparam int LIMIT = 2 * NREC + 20;  // cycle budget for the whole run

  logic                        clk;
  logic                        rst;
  logic                        fetch_valid;
  decode_pipe_pkg::fetch_pkt_t fetch;
  logic                        dec_valid;
  decode_pipe_pkg::dec_pkt_t   dec;

  logic [63:0] vec [0:NREC*WPR-1];
  decode_pipe_pkg::dec_pkt_t exp_q[$];  // expected packets in drive order
  int                        due_q[$];  // cycle at which each one is due
  decode_pipe_pkg::dec_pkt_t exp_pkt;
  int                        cyc;
  int                        seed;

  decode_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .dec_valid   (dec_valid),
    .dec         (dec)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "decode_tb stopped");
  endtask

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    abort_run($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      report_mismatch(name, 64'(exp), 64'(act));
    end
  endtask

  task automatic check_group(logic [decode_pipe_pkg::LANES-1:0] exp,
                             logic [decode_pipe_pkg::LANES-1:0] act);
    if (act !== exp) begin
      report_mismatch("dec.group_end", 64'(exp), 64'(act));
    end
  endtask

  // fields of an invalid slot are don't care
  task automatic check_op(int slot, decode_pipe_pkg::dec_op_t exp,
                          decode_pipe_pkg::dec_op_t act);
    string base;
    base = $sformatf("dec.ops[%0d]", slot);
    check_valid({base, ".valid"}, exp.valid, act.valid);
    if (exp.valid) begin
      if (act.pc !== exp.pc) report_mismatch({base, ".pc"}, exp.pc, act.pc);
      if (act.op !== exp.op) report_mismatch({base, ".op"}, 64'(exp.op), 64'(act.op));
      if (act.rd !== exp.rd) report_mismatch({base, ".rd"}, 64'(exp.rd), 64'(act.rd));
      if (act.rs1 !== exp.rs1) report_mismatch({base, ".rs1"}, 64'(exp.rs1), 64'(act.rs1));
      if (act.rs2 !== exp.rs2) report_mismatch({base, ".rs2"}, 64'(exp.rs2), 64'(act.rs2));
      if (act.imm !== exp.imm) report_mismatch({base, ".imm"}, exp.imm, act.imm);
      check_valid({base, ".illegal"}, exp.illegal, act.illegal);
      check_valid({base, ".uses_rs1"}, exp.uses_rs1, act.uses_rs1);
      check_valid({base, ".uses_rs2"}, exp.uses_rs2, act.uses_rs2);
      check_valid({base, ".writes_rd"}, exp.writes_rd, act.writes_rd);
      check_valid({base, ".is_ebreak"}, exp.is_ebreak, act.is_ebreak);
    end
  endtask

  // operand use per instruction class as {uses_rs1, uses_rs2, writes_rd}
  function automatic logic [2:0] operand_use(rv_isa_pkg::op_e op);
    logic [2:0] flags;
    case (op)
      rv_isa_pkg::OP_ILLEGAL: flags = 3'b000;
      rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC,
      rv_isa_pkg::OP_JAL: flags = 3'b001;                   // U and J
      rv_isa_pkg::OP_BNE, rv_isa_pkg::OP_SH,
      rv_isa_pkg::OP_SD: flags = 3'b110;                    // S and B
      rv_isa_pkg::OP_ADD, rv_isa_pkg::OP_SUB, rv_isa_pkg::OP_SLTU, rv_isa_pkg::OP_OR,
      rv_isa_pkg::OP_AND, rv_isa_pkg::OP_ADDW, rv_isa_pkg::OP_SLLW: flags = 3'b111;
      default: flags = 3'b101;                              // I format, ebreak too
    endcase
    return flags;
  endfunction

  // meta word holds valid and illegal nibbles, then op, rd, rs1, rs2 bytes
  function automatic decode_pipe_pkg::dec_pkt_t expected_packet(int r);
    decode_pipe_pkg::dec_pkt_t pkt;
    logic [63:0]               meta;
    int                        b;
    b   = r * WPR;
    pkt = '0;
    pkt.valid     = vec[b+6][0];
    pkt.group_end = vec[b+7][decode_pipe_pkg::LANES-1:0];
    for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
      meta               = vec[b+8+2*i];
      pkt.ops[i].valid   = meta[36];
      pkt.ops[i].illegal = meta[32];
      pkt.ops[i].op      = rv_isa_pkg::op_e'(meta[28:24]);
      pkt.ops[i].rd      = meta[20:16];
      pkt.ops[i].rs1     = meta[12:8];
      pkt.ops[i].rs2     = meta[4:0];
      pkt.ops[i].imm     = vec[b+9+2*i];
      pkt.ops[i].pc      = vec[b+1] + 64'(4 * i); // slot pc steps by one word
      {pkt.ops[i].uses_rs1, pkt.ops[i].uses_rs2, pkt.ops[i].writes_rd} =
        operand_use(pkt.ops[i].op);
      pkt.ops[i].is_ebreak = (pkt.ops[i].op == rv_isa_pkg::OP_EBREAK);
    end
    return pkt;
  endfunction

  // cycle counter doubles as the watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      abort_run($sformatf("timeout after %0d cycles with %0d packets outstanding",
                          cyc, exp_q.size()));
    end
  end

  // registered outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (exp_q.size() > 0 && due_q[0] == cyc) begin
        if (dec_valid !== 1'b1) begin
          abort_run($sformatf("dec_valid missing at cycle %0d, three cycles after its strobe",
                              cyc));
        end
        exp_pkt = exp_q.pop_front();
        void'(due_q.pop_front());
        check_valid("dec_valid", exp_pkt.valid, dec_valid);
        check_valid("dec.valid", exp_pkt.valid, dec.valid);
        for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
          check_op(i, exp_pkt.ops[i], dec.ops[i]);
        end
        check_group(exp_pkt.group_end, dec.group_end);
      end else if (dec_valid !== 1'b0) begin
        abort_run($sformatf("dec_valid high at cycle %0d with no packet due", cyc));
      end
    end
  end

  initial begin
    int b;
    seed        = 78;
    cyc         = 0;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch       = '0;
    $readmemh("verif/decode_testdata.hex", vec);
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    for (int r = 0; r < NREC; r++) begin
      b = r * WPR;
      if (($random(seed) & 3) == 0) begin
        @(posedge clk);
        #1 fetch_valid = 1'b0; // idle gap
      end
      @(posedge clk);
      #1;
      fetch_valid = 1'b1;
      fetch.mask  = vec[b][decode_pipe_pkg::LANES-1:0];
      fetch.pc    = vec[b+1];
      for (int i = 0; i < decode_pipe_pkg::LANES; i++) begin
        fetch.insts[i] = vec[b+2+i][31:0];
      end
      exp_q.push_back(expected_packet(r));
      due_q.push_back(cyc + 3);
    end
    @(posedge clk);
    #1 fetch_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (3) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

/* verif/decode_testdata.hex */
// mask pc inst0 inst1 inst2 inst3 dec_valid group_end, then per slot: meta imm
// meta = valid illegal op[7:0] rd[7:0] rs1[7:0] rs2[7:0]; imm is the full 64-bit value
// I format: addi, addi x0-based negative, lw, lbu negative
f 1000 00510093 fff00193 0082a203 ffc3c303 1 8 1006010205 5 100603001f ffffffffffffffff 1003040508 8 100406071c fffffffffffffffc
// S and B formats with sltiu
f 2000 fe849f23 00a5b823 fe209ce3 0646b613 1 8 10051e0908 fffffffffffffffe 100b100b0a 10 1002190102 fffffffffffffff8 10070c0d04 64
// U and J formats, negative auipc and jal
f 80000000 123452b7 80000317 001000ef ffdff06f 1 8 100d050803 12345000 100e060000 ffffffff80000000 100f010001 800 100f001f1d fffffffffffffffc
// R chain add sub sltu or, every slot ends a group
f 3000 003100b3 40508233 0043b333 00936433 1 f 1010010203 0 1011040105 0 1012060704 0 1013080609 0
// and addw sllw srai chain, srai shamt 33
f 4000 00c5f533 000506bb 00d7973b 42175813 1 f 10140a0b0c 0 10150d0a00 0 10160e0f0d 0 1017100e01 21
// write to x0 and unused source fields give no group end
f 5000 00108013 00000133 00220193 000183b7 1 8 1006000101 1 1010020000 0 1006030402 2 100d070300 18000
// mask 0101 with a dependency across a masked slot
5 6000 fff14093 00510093 0ff0f193 00000000 1 5 100801021f ffffffffffffffff 0 0 100903011f ff 0 0
// only slot 3 valid
8 7000 00000000 00000000 00000000 01813483 1 8 0 0 0 0 0 0 100a090218 18
// unlisted encodings: zero word, sll, subw, srli
f 8000 00000000 003110b3 4062823b 00345393 1 8 1100000000 0 1100010203 0 1100040506 0 1100070803 0
// ebreak in slot 1 squashes slots 2 and 3
f 9000 00510093 00100073 003100b3 00000000 1 2 1006010205 5 1018000001 1 0 0 0 0
// ebreak in slot 0
f a000 00100073 00510093 003100b3 00000000 1 1 1018000001 1 0 0 0 0 0 0
// mul illegal, addw versus sllw, sub reading both
f b000 023100b3 007302bb 007312bb 40528433 1 e 1100010203 0 1015050607 0 1016050607 0 1011080505 0
// jalr ld sd addiw, pc crosses a 64 KiB boundary
f fff8 000280e7 ff80b103 0021b023 8002021b 1 b 1001010500 0 100a020118 fffffffffffffff8 100b000302 0 100c040400 fffffffffffff800
// mask 0110, lui feeding or
6 c000 00000000 000184b7 0094e533 00000000 1 6 0 0 100d090300 18000 10130a0909 0 0 0
